// ==== rec_exec.f ====
src/rec_pkg.sv
src/rec_indirect_fifo.sv
src/rec_resp_serializer.sv
src/rec_csr_bank.sv
src/rec_cmd_fsm.sv
src/rec_exec_top.sv
bench/rec_exec_tb.sv

// ==== bench/rec_exec_tb.sv ====
// Table-driven testbench for the recovery executor with RX queue model and compare tasks
module rec_exec_tb
  import rec_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumTests   = 22;
  localparam int CmdLimit   = 150;
  localparam int CycleLimit = 40 * NumTests + 200;
  localparam int KindWr     = 0;
  localparam int KindErr    = 1;
  localparam int KindRd     = 2;
  localparam int KindPop    = 3;

  logic             clk_i, rst_ni;
  logic             cmd_valid_i, cmd_is_rd_i, cmd_error_i, recovery_mode_i;
  logic [7:0]       cmd_code_i;
  logic [LenW-1:0]  cmd_len_i;
  logic             cmd_done_o, rx_rreq_o, rx_rack_i, rx_queue_clr_o;
  logic [WordW-1:0] rx_rdata_i;
  logic             res_valid_o, res_ready_i, res_dvalid_o, res_dready_i, res_dlast_o;
  logic [LenW-1:0]  res_len_o;
  logic [7:0]       res_data_o;
  logic             fifo_rreq_i, fifo_rack_o;
  logic [WordW-1:0] fifo_rdata_o;
  logic             payload_available_o, image_activated_o;

  // One row per command
  // For reads len is the expected response length
  string            t_name [NumTests];
  logic             t_rd   [NumTests];
  logic [7:0]       t_code [NumTests];
  logic [LenW-1:0]  t_len  [NumTests];
  logic             t_crc  [NumTests];
  logic             t_mode [NumTests];
  // Payload words or expected bytes with the lowest first
  logic [159:0]     t_data [NumTests];
  int               t_kind [NumTests];
  logic             t_img  [NumTests];
  logic             t_pay  [NumTests];
  int               n_rows;

  integer seed   = 90;
  int     cycles = 0;

  rec_exec_top #(.FifoDepth(64)) DUT (.*);

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > CycleLimit) report_failure("cycle limit reached before the table finished");
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      report_failure($sformatf("MISMATCH %s expected %0h actual %0h", name, exp, act));
    end
  endtask

  task automatic check_len(input string name, input logic [LenW-1:0] exp,
                           input logic [LenW-1:0] act);
    if (act !== exp) begin
      report_failure($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic check_word(input string name, input logic [WordW-1:0] exp,
                            input logic [WordW-1:0] act);
    if (act !== exp) begin
      report_failure($sformatf("MISMATCH %s expected %0h actual %0h", name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      report_failure($sformatf("MISMATCH %s expected %0b actual %0b", name, exp, act));
    end
  endtask

  task automatic add_entry(input string name, input int rd, input int code, input int len,
                           input int crc, input int mode, input logic [159:0] data,
                           input int kind, input int img, input int pay);
    t_name[n_rows] = name;
    t_rd[n_rows]   = (rd != 0);
    t_code[n_rows] = 8'(code);
    t_len[n_rows]  = LenW'(len);
    t_crc[n_rows]  = (crc != 0);
    t_mode[n_rows] = (mode != 0);
    t_data[n_rows] = data;
    t_kind[n_rows] = kind;
    t_img[n_rows]  = (img != 0);
    t_pay[n_rows]  = (pay != 0);
    n_rows++;
  endtask

  task automatic load_table();
    // Image activation and register round trips
    add_entry("wr_recovery_ctrl", 0, 38, 3, 0, 0, 160'h000F0201, KindWr, 1, 0);
    add_entry("rd_recovery_ctrl", 1, 38, 3, 0, 0, 160'h0F0201, KindRd, 1, 0);
    add_entry("wr_device_reset", 0, 37, 3, 0, 0, 160'h00AABBCC, KindWr, 1, 0);
    add_entry("rd_device_reset", 1, 37, 3, 0, 0, 160'hAABBCC, KindRd, 1, 0);
    add_entry("wr_recovery_ctrl_off", 0, 38, 3, 0, 0, 160'h00050403, KindWr, 0, 0);
    add_entry("rd_recovery_ctrl_off", 1, 38, 3, 0, 0, 160'h050403, KindRd, 0, 0);
    // Illegal commands end with the CRC error that the status read reports
    add_entry("err_code_33", 0, 33, 4, 0, 1, 160'h1, KindErr, 0, 0);
    add_entry("err_code_48", 1, 48, 4, 0, 1, 160'h0, KindErr, 0, 0);
    add_entry("err_fifo_ctrl_mode_off", 0, 45, 4, 0, 0, 160'h1, KindErr, 0, 0);
    add_entry("err_unsupported_34", 1, 34, 4, 0, 1, 160'h0, KindErr, 0, 0);
    add_entry("err_crc", 0, 38, 3, 1, 0, 160'h000F0000, KindErr, 0, 0);
    add_entry("rd_status_crc", 1, 36, 7, 0, 0, 160'h0400, KindRd, 0, 0);
    add_entry("rd_status_ok", 1, 36, 7, 0, 0, 160'h0, KindRd, 0, 0);
    // Indirect FIFO fill, status and drain
    add_entry("wr_fifo_data", 0, 47, 12, 0, 1, 160'h99AABBCC_55667788_11223344, KindWr, 0, 1);
    add_entry("rd_fifo_status", 1, 46, 20, 0, 1, {32'd0, 32'd64, 32'd0, 32'd3, 32'd0},
              KindRd, 0, 1);
    add_entry("pop_word_0", 0, 0, 0, 0, 0, 160'h11223344, KindPop, 0, 1);
    add_entry("pop_word_1", 0, 0, 0, 0, 0, 160'h55667788, KindPop, 0, 1);
    add_entry("pop_word_2", 0, 0, 0, 0, 0, 160'h99AABBCC, KindPop, 0, 0);
    // FIFO clear through FIFO_CTRL byte 1
    add_entry("wr_fifo_data_2", 0, 47, 8, 0, 1, 160'hCAFE0002_CAFE0001, KindWr, 0, 1);
    add_entry("wr_fifo_ctrl_clear", 0, 45, 6, 0, 1, 160'h00000100, KindWr, 0, 0);
    add_entry("rd_fifo_status_clr", 1, 46, 20, 0, 1, {32'd0, 32'd64, 32'd0, 32'd0, 32'd1},
              KindRd, 0, 0);
    add_entry("wr_zero_length", 0, 38, 0, 0, 0, 160'h0, KindWr, 0, 0);
  endtask

  task automatic pop_fifo_word(input int i);
    int waited;
    waited = 0;
    @(negedge clk_i);
    fifo_rreq_i = 1'b1;
    @(negedge clk_i);
    fifo_rreq_i = 1'b0;
    while (!fifo_rack_o) begin
      @(negedge clk_i);
      waited++;
      if (waited > 10) report_failure($sformatf("no FIFO read ack for %s", t_name[i]));
    end
    check_word(t_name[i], t_data[i][WordW-1:0], fifo_rdata_o);
  endtask

  // Issues one command, serves the RX queue and collects the response
  task automatic apply_command(input int i);
    int   waited, n_req, n_clr, n_valid, n_bytes, rx_idx, rx_wait;
    logic rx_pending, done;
    waited = 0;
    n_req = 0;
    n_clr = 0;
    n_valid = 0;
    n_bytes = 0;
    rx_idx = 0;
    rx_wait = 0;
    rx_pending = 1'b0;
    done = 1'b0;
    @(negedge clk_i);
    cmd_valid_i     = 1'b1;
    cmd_is_rd_i     = t_rd[i];
    cmd_code_i      = t_code[i];
    // Read commands carry no byte length of their own
    cmd_len_i       = t_rd[i] ? '0 : t_len[i];
    cmd_error_i     = t_crc[i];
    recovery_mode_i = t_mode[i];
    while (!done) begin
      @(negedge clk_i);
      cmd_valid_i = 1'b0;
      waited++;
      if (waited > CmdLimit) report_failure($sformatf("no cmd_done after command %s", t_name[i]));
      done = cmd_done_o;
      if (rx_queue_clr_o) n_clr++;
      if (res_valid_o) begin
        n_valid++;
        check_len({t_name[i], " res_len"}, t_len[i], res_len_o);
      end
      res_ready_i = ($random(seed) % 4) != 0;
      // RX queue answers after 0..3 cycles
      rx_rack_i = 1'b0;
      if (rx_rreq_o) begin
        n_req++;
        rx_pending = 1'b1;
        rx_wait = $unsigned($random(seed)) % 4;
      end
      if (rx_pending && rx_wait == 0) begin
        rx_rack_i  = 1'b1;
        rx_rdata_i = t_data[i][32*rx_idx +: 32];
        rx_idx++;
        rx_pending = 1'b0;
      end else if (rx_pending) begin
        rx_wait--;
      end
      // Byte and last marker must hold while not accepted
      res_dready_i = ($random(seed) % 4) != 0;
      if (res_dvalid_o) begin
        check_byte($sformatf("%s byte %0d", t_name[i], n_bytes), t_data[i][8*n_bytes +: 8],
                   res_data_o);
        check_flag($sformatf("%s last %0d", t_name[i], n_bytes),
                   n_bytes == int'(t_len[i]) - 1, res_dlast_o);
        if (res_dready_i) n_bytes++;
      end
    end
    case (t_kind[i])
      KindErr: begin
        check_flag({t_name[i], " queue clear"}, 1'b1, n_clr == 1);
        check_flag({t_name[i], " response"}, 1'b0, n_valid != 0);
        check_len({t_name[i], " requests"}, '0, LenW'(n_req));
      end
      KindRd: check_len({t_name[i], " bytes"}, t_len[i], LenW'(n_bytes));
      default: begin
        check_len({t_name[i], " requests"}, (t_len[i] + LenW'(3)) >> 2, LenW'(n_req));
        check_flag({t_name[i], " queue clear"}, 1'b0, n_clr != 0);
      end
    endcase
  endtask

  initial begin
    cmd_valid_i     = 1'b0;
    cmd_is_rd_i     = 1'b0;
    cmd_code_i      = '0;
    cmd_len_i       = '0;
    cmd_error_i     = 1'b0;
    recovery_mode_i = 1'b0;
    rx_rack_i       = 1'b0;
    rx_rdata_i      = '0;
    res_ready_i     = 1'b0;
    res_dready_i    = 1'b0;
    fifo_rreq_i     = 1'b0;
    rst_ni          = 1'b0;
    n_rows          = 0;
    load_table();
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_flag("reset cmd_done", 1'b0, cmd_done_o);
    check_flag("reset res_valid", 1'b0, res_valid_o);
    check_flag("reset res_dvalid", 1'b0, res_dvalid_o);
    check_flag("reset rx_rreq", 1'b0, rx_rreq_o);
    check_flag("reset rx_queue_clr", 1'b0, rx_queue_clr_o);
    check_flag("reset fifo_rack", 1'b0, fifo_rack_o);
    check_flag("reset payload_available", 1'b0, payload_available_o);
    check_flag("reset image_activated", 1'b0, image_activated_o);
    for (int i = 0; i < n_rows; i++) begin
      if (t_kind[i] == KindPop) begin
        pop_fifo_word(i);
      end else begin
        apply_command(i);
      end
      // Flags settle one cycle after the FIFO drains
      repeat (2) @(negedge clk_i);
      check_flag({t_name[i], " image_activated"}, t_img[i], image_activated_o);
      check_flag({t_name[i], " payload_available"}, t_pay[i], payload_available_o);
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== src/rec_exec_top.sv ====
// Recovery command executor top level with FSM, register bank, FIFO and serializer
module rec_exec_top
  import rec_pkg::*;
#(
  parameter int unsigned FifoDepth = 64
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             cmd_valid_i,
  input  logic             cmd_is_rd_i,
  input  logic [7:0]       cmd_code_i,
  input  logic [LenW-1:0]  cmd_len_i,
  input  logic             cmd_error_i,
  input  logic             recovery_mode_i,
  output logic             cmd_done_o,
  output logic             rx_rreq_o,
  input  logic             rx_rack_i,
  input  logic [WordW-1:0] rx_rdata_i,
  output logic             rx_queue_clr_o,
  output logic             res_valid_o,
  input  logic             res_ready_i,
  output logic [LenW-1:0]  res_len_o,
  output logic             res_dvalid_o,
  input  logic             res_dready_i,
  output logic [7:0]       res_data_o,
  output logic             res_dlast_o,
  input  logic             fifo_rreq_i,
  output logic             fifo_rack_o,
  output logic [WordW-1:0] fifo_rdata_o,
  output logic             payload_available_o,
  output logic             image_activated_o
);

  csr_e             csr_sel;
  logic             wr_en, fifo_push, fifo_clr;
  logic             read_start, word_next, read_end;
  logic [LenW-1:0]  read_len;
  logic             status_we;
  prot_status_e     prot_status;
  logic [WordW-1:0] rd_word, fifo_wr_idx, fifo_rd_idx;
  logic             fifo_full, fifo_empty;

  // Response length is the latched register length
  assign res_len_o = read_len;

  rec_cmd_fsm u_cmd_fsm (
    .clk_i, .rst_ni, .cmd_valid_i, .cmd_is_rd_i, .cmd_code_i, .cmd_len_i, .cmd_error_i,
    .recovery_mode_i, .rx_rack_i, .res_ready_i, .word_next_i(word_next),
    .read_end_i(read_end), .cmd_done_o, .rx_rreq_o, .rx_queue_clr_o,
    .csr_sel_o(csr_sel), .wr_en_o(wr_en), .fifo_push_o(fifo_push),
    .read_start_o(read_start), .read_len_o(read_len), .res_valid_o,
    .status_we_o(status_we), .prot_status_o(prot_status)
  );

  rec_csr_bank #(.FifoDepth(FifoDepth)) u_csr_bank (
    .clk_i, .rst_ni, .csr_sel_i(csr_sel), .wr_en_i(wr_en), .wr_data_i(rx_rdata_i),
    .status_we_i(status_we), .prot_status_i(prot_status), .fifo_full_i(fifo_full),
    .fifo_empty_i(fifo_empty), .fifo_wr_idx_i(fifo_wr_idx), .fifo_rd_idx_i(fifo_rd_idx),
    .rd_word_o(rd_word), .fifo_clr_o(fifo_clr), .image_activated_o
  );

  rec_indirect_fifo #(.FifoDepth(FifoDepth)) u_indirect_fifo (
    .clk_i, .rst_ni, .push_i(fifo_push), .push_data_i(rx_rdata_i), .clr_i(fifo_clr),
    .rreq_i(fifo_rreq_i), .rack_o(fifo_rack_o), .rdata_o(fifo_rdata_o),
    .full_o(fifo_full), .empty_o(fifo_empty), .wr_idx_o(fifo_wr_idx),
    .rd_idx_o(fifo_rd_idx), .payload_available_o
  );

  rec_resp_serializer u_resp_serializer (
    .clk_i, .rst_ni, .start_i(read_start), .len_i(read_len), .word_i(rd_word),
    .dready_i(res_dready_i), .dvalid_o(res_dvalid_o), .data_o(res_data_o),
    .dlast_o(res_dlast_o), .word_next_o(word_next), .end_o(read_end)
  );

endmodule

// ==== src/rec_cmd_fsm.sv ====
// Command FSM with legality check, register selection and write-word counting
module rec_cmd_fsm
  import rec_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            cmd_valid_i,
  input  logic            cmd_is_rd_i,
  input  logic [7:0]      cmd_code_i,
  input  logic [LenW-1:0] cmd_len_i,
  input  logic            cmd_error_i,
  input  logic            recovery_mode_i,
  input  logic            rx_rack_i,
  input  logic            res_ready_i,
  input  logic            word_next_i,
  input  logic            read_end_i,
  output logic            cmd_done_o,
  output logic            rx_rreq_o,
  output logic            rx_queue_clr_o,
  output csr_e            csr_sel_o,
  output logic            wr_en_o,
  output logic            fifo_push_o,
  output logic            read_start_o,
  output logic [LenW-1:0] read_len_o,
  output logic            res_valid_o,
  output logic            status_we_o,
  output prot_status_e    prot_status_o
);

  state_e          state_q, state_d;
  csr_e            sel_d, csr_sel_q, sel_step;
  logic [LenW-1:0] len_d, csr_len_q;
  logic [LenW-1:0] words_d, dcnt_q;
  logic            supported, legal, rreq_d;
  prot_status_e    prot_q;

  // Selector and byte length per code
  always_comb begin
    sel_d     = CSR_INVALID;
    len_d     = '0;
    supported = 1'b1;
    case (cmd_code_i)
      CMD_DEVICE_STATUS: begin
        sel_d = CSR_DEVICE_STATUS_0;
        len_d = LenDeviceStatus;
      end
      CMD_DEVICE_RESET: begin
        sel_d = CSR_DEVICE_RESET;
        len_d = LenDeviceReset;
      end
      CMD_RECOVERY_CTRL: begin
        sel_d = CSR_RECOVERY_CTRL;
        len_d = LenRecoveryCtrl;
      end
      CMD_INDIRECT_FIFO_CTRL: begin
        sel_d = CSR_FIFO_CTRL_0;
        len_d = LenFifoCtrl;
      end
      CMD_INDIRECT_FIFO_STATUS: begin
        sel_d = CSR_FIFO_STATUS_0;
        len_d = LenFifoStatus;
      end
      // Write only, there is no register behind it
      CMD_INDIRECT_FIFO_DATA: supported = !cmd_is_rd_i;
      default: supported = 1'b0;
    endcase
  end

  assign legal = !cmd_error_i && (cmd_code_i >= CmdFirst) && (cmd_code_i <= CmdLast) &&
                 (recovery_mode_i || (cmd_code_i <= CmdLastNormal)) && supported;

  // Byte length rounded up to whole words
  assign words_d = {2'b00, cmd_len_i[LenW-1:2]} + LenW'(|cmd_len_i[1:0]);

  // Saturates at INVALID once past the last register word
  assign sel_step = (csr_sel_q < CSR_FIFO_STATUS_4) ? csr_e'(csr_sel_q + 8'd1) : CSR_INVALID;

  always_comb begin
    state_d = state_q;
    rreq_d  = 1'b0;
    case (state_q)
      Idle: begin
        if (cmd_valid_i) begin
          if (!legal) begin
            state_d = Error;
          end else if (cmd_is_rd_i) begin
            state_d = CsrRead;
          end else if (words_d == '0) begin
            state_d = Done;
          end else begin
            state_d = (cmd_code_i == CMD_INDIRECT_FIFO_DATA) ? FifoWrite : CsrWrite;
            rreq_d  = 1'b1;
          end
        end
      end
      CsrWrite, FifoWrite: begin
        if (rx_rack_i) begin
          if (dcnt_q == LenW'(1)) begin
            state_d = Done;
          end else begin
            rreq_d = 1'b1;
          end
        end
      end
      CsrRead: if (res_ready_i) state_d = CsrReadData;
      CsrReadData: if (read_end_i) state_d = Done;
      Error: state_d = Done;
      Done: state_d = Idle;
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= Idle;
      rx_rreq_o <= 1'b0;
      csr_sel_q <= CSR_INVALID;
      csr_len_q <= '0;
      dcnt_q    <= '0;
      prot_q    <= PROT_OK;
    end else begin
      state_q   <= state_d;
      rx_rreq_o <= rreq_d;
      if (state_q == Idle && cmd_valid_i) begin
        csr_sel_q <= sel_d;
        csr_len_q <= len_d;
        dcnt_q    <= words_d;
        prot_q    <= cmd_error_i ? PROT_ERROR_CRC : PROT_OK;
      end else if (state_q == CsrWrite && rx_rack_i) begin
        csr_sel_q <= sel_step;
        dcnt_q    <= dcnt_q - LenW'(1);
      end else if (state_q == FifoWrite && rx_rack_i) begin
        dcnt_q <= dcnt_q - LenW'(1);
      end else if (state_q == CsrReadData && word_next_i) begin
        csr_sel_q <= sel_step;
      end
    end
  end

  assign cmd_done_o     = (state_q == Done);
  assign rx_queue_clr_o = (state_q == Error);
  assign csr_sel_o      = csr_sel_q;
  assign wr_en_o        = (state_q == CsrWrite) && rx_rack_i;
  assign fifo_push_o    = (state_q == FifoWrite) && rx_rack_i;
  assign res_valid_o    = (state_q == CsrRead);
  assign read_start_o   = (state_q == CsrRead) && res_ready_i;
  assign read_len_o     = csr_len_q;
  // Status recorded as each command ends
  assign status_we_o    = (state_q == Done);
  assign prot_status_o  = prot_q;

endmodule

// ==== src/rec_csr_bank.sv ====
// Recovery register bank, protocol status, read mux and image-activated flag
module rec_csr_bank
  import rec_pkg::*;
#(
  parameter int unsigned FifoDepth = 64
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  csr_e             csr_sel_i,
  input  logic             wr_en_i,
  input  logic [WordW-1:0] wr_data_i,
  input  logic             status_we_i,
  input  prot_status_e     prot_status_i,
  input  logic             fifo_full_i,
  input  logic             fifo_empty_i,
  input  logic [WordW-1:0] fifo_wr_idx_i,
  input  logic [WordW-1:0] fifo_rd_idx_i,
  output logic [WordW-1:0] rd_word_o,
  output logic             fifo_clr_o,
  output logic             image_activated_o
);

  logic [23:0]      device_reset_q;
  logic [23:0]      recovery_ctrl_q;
  logic [15:0]      fifo_ctrl_0_q;
  logic [WordW-1:0] fifo_ctrl_1_q;
  prot_status_e     prot_status_q;

  // Writable registers; other selectors drop the word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      device_reset_q  <= '0;
      recovery_ctrl_q <= '0;
      fifo_ctrl_0_q   <= '0;
      fifo_ctrl_1_q   <= '0;
    end else if (wr_en_i) begin
      case (csr_sel_i)
        CSR_DEVICE_RESET:  device_reset_q  <= wr_data_i[23:0];
        CSR_RECOVERY_CTRL: recovery_ctrl_q <= wr_data_i[23:0];
        CSR_FIFO_CTRL_0:   fifo_ctrl_0_q   <= wr_data_i[15:0];
        CSR_FIFO_CTRL_1:   fifo_ctrl_1_q   <= wr_data_i;
        default: ;
      endcase
    end
  end

  // Protocol status of the last finished command
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prot_status_q <= PROT_OK;
    end else if (status_we_i) begin
      prot_status_q <= prot_status_i;
    end
  end

  // FIFO reset request is byte 1 of FIFO_CTRL_0
  assign fifo_clr_o = wr_en_i && (csr_sel_i == CSR_FIFO_CTRL_0) && (wr_data_i[15:8] == 8'd1);

  assign image_activated_o = (recovery_ctrl_q[23:16] == ImageActivateCode);

  // Read mux, follows the selector in the same cycle
  always_comb begin
    case (csr_sel_i)
      CSR_DEVICE_STATUS_0: rd_word_o = {16'h0000, prot_status_q, 8'h00};
      CSR_DEVICE_RESET:    rd_word_o = {8'h00, device_reset_q};
      CSR_RECOVERY_CTRL:   rd_word_o = {8'h00, recovery_ctrl_q};
      CSR_FIFO_CTRL_0:     rd_word_o = {16'h0000, fifo_ctrl_0_q};
      CSR_FIFO_CTRL_1:     rd_word_o = fifo_ctrl_1_q;
      CSR_FIFO_STATUS_0:   rd_word_o = {30'd0, fifo_full_i, fifo_empty_i};
      CSR_FIFO_STATUS_1:   rd_word_o = fifo_wr_idx_i;
      CSR_FIFO_STATUS_2:   rd_word_o = fifo_rd_idx_i;
      CSR_FIFO_STATUS_3:   rd_word_o = WordW'(FifoDepth);
      // DEVICE_STATUS_1, FIFO_STATUS_4 and INVALID read as zero
      default:             rd_word_o = '0;
    endcase
  end

endmodule

// ==== src/rec_resp_serializer.sv ====
// Read response byte streamer with remaining-byte count and last marker
module rec_resp_serializer
  import rec_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             start_i,
  input  logic [LenW-1:0]  len_i,
  input  logic [WordW-1:0] word_i,
  input  logic             dready_i,
  output logic             dvalid_o,
  output logic [7:0]       data_o,
  output logic             dlast_o,
  output logic             word_next_o,
  output logic             end_o
);

  logic [LenW-1:0] remain_q;
  logic [1:0]      lane_q;
  logic            hs;

  assign hs = dvalid_o && dready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dvalid_o <= 1'b0;
      remain_q <= '0;
      lane_q   <= '0;
    end else if (start_i) begin
      dvalid_o <= (len_i != '0);
      remain_q <= len_i;
      lane_q   <= '0;
    end else if (hs) begin
      remain_q <= remain_q - LenW'(1);
      lane_q   <= lane_q + 2'd1;
      if (remain_q == LenW'(1)) dvalid_o <= 1'b0;
    end
  end

  // Least significant byte first
  always_comb begin
    case (lane_q)
      2'd0:    data_o = word_i[7:0];
      2'd1:    data_o = word_i[15:8];
      2'd2:    data_o = word_i[23:16];
      default: data_o = word_i[31:24];
    endcase
  end

  assign dlast_o     = dvalid_o && (remain_q == LenW'(1));
  assign word_next_o = hs && (lane_q == 2'd3);
  assign end_o       = hs && (remain_q == LenW'(1));

endmodule

// ==== src/rec_indirect_fifo.sv ====
// Indirect image FIFO with indices, clear, full/empty and payload-available flag
module rec_indirect_fifo
  import rec_pkg::*;
#(
  parameter int unsigned FifoDepth = 64
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  logic [WordW-1:0] push_data_i,
  input  logic             clr_i,
  input  logic             rreq_i,
  output logic             rack_o,
  output logic [WordW-1:0] rdata_o,
  output logic             full_o,
  output logic             empty_o,
  output logic [WordW-1:0] wr_idx_o,
  output logic [WordW-1:0] rd_idx_o,
  output logic             payload_available_o
);

  localparam int unsigned AddrW = $clog2(FifoDepth);

  logic [WordW-1:0] mem [FifoDepth];
  // One extra bit tells full from empty
  logic [AddrW:0]   wr_ptr_q, rd_ptr_q;
  logic             push_ok, pop_ok;

  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full_o  = (wr_ptr_q[AddrW] != rd_ptr_q[AddrW]) &&
                   (wr_ptr_q[AddrW-1:0] == rd_ptr_q[AddrW-1:0]);

  // Push into a full FIFO is dropped
  assign push_ok = push_i && !full_o && !clr_i;
  assign pop_ok  = rreq_i && !empty_o && !clr_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q            <= '0;
      rd_ptr_q            <= '0;
      rack_o              <= 1'b0;
      payload_available_o <= 1'b0;
    end else begin
      rack_o <= pop_ok;
      if (clr_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
      end else begin
        if (push_ok) wr_ptr_q <= wr_ptr_q + 1'b1;
        if (pop_ok) rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Set by the first word, dropped once drained
      if (!payload_available_o && push_ok) begin
        payload_available_o <= 1'b1;
      end else if (payload_available_o && empty_o) begin
        payload_available_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_ok) mem[wr_ptr_q[AddrW-1:0]] <= push_data_i;
    if (pop_ok) rdata_o <= mem[rd_ptr_q[AddrW-1:0]];
  end

  assign wr_idx_o = WordW'(wr_ptr_q[AddrW-1:0]);
  assign rd_idx_o = WordW'(rd_ptr_q[AddrW-1:0]);

endmodule

// ==== src/rec_pkg.sv ====
// Shared widths, command, register, state and status types, register lengths
package rec_pkg;

  // Payload and register word width
  localparam int unsigned WordW = 32;
  // Command and response length width
  localparam int unsigned LenW = 16;

  // Supported command codes
  typedef enum logic [7:0] {
    CMD_DEVICE_STATUS        = 8'd36,
    CMD_DEVICE_RESET         = 8'd37,
    CMD_RECOVERY_CTRL        = 8'd38,
    CMD_INDIRECT_FIFO_CTRL   = 8'd45,
    CMD_INDIRECT_FIFO_STATUS = 8'd46,
    CMD_INDIRECT_FIFO_DATA   = 8'd47
  } command_e;

  // Bounds of the command code space
  localparam logic [7:0] CmdFirst      = 8'd34;
  localparam logic [7:0] CmdLastNormal = 8'd39;
  localparam logic [7:0] CmdLast       = 8'd47;

  // Register word selector, consecutive up to the last FIFO status word
  typedef enum logic [7:0] {
    CSR_DEVICE_STATUS_0 = 8'd0,
    CSR_DEVICE_STATUS_1 = 8'd1,
    CSR_DEVICE_RESET    = 8'd2,
    CSR_RECOVERY_CTRL   = 8'd3,
    CSR_FIFO_CTRL_0     = 8'd4,
    CSR_FIFO_CTRL_1     = 8'd5,
    CSR_FIFO_STATUS_0   = 8'd6,
    CSR_FIFO_STATUS_1   = 8'd7,
    CSR_FIFO_STATUS_2   = 8'd8,
    CSR_FIFO_STATUS_3   = 8'd9,
    CSR_FIFO_STATUS_4   = 8'd10,
    CSR_INVALID         = 8'hFF
  } csr_e;

  // Executor states
  typedef enum logic [2:0] {
    Idle,
    CsrWrite,
    FifoWrite,
    CsrRead,
    CsrReadData,
    Error,
    Done
  } state_e;

  // Protocol status codes
  typedef enum logic [7:0] {
    PROT_OK        = 8'h00,
    PROT_ERROR_CRC = 8'h04
  } prot_status_e;

  // Register lengths in bytes
  localparam logic [LenW-1:0] LenDeviceStatus = 16'd7;
  localparam logic [LenW-1:0] LenDeviceReset  = 16'd3;
  localparam logic [LenW-1:0] LenRecoveryCtrl = 16'd3;
  localparam logic [LenW-1:0] LenFifoCtrl     = 16'd6;
  localparam logic [LenW-1:0] LenFifoStatus   = 16'd20;

  // RECOVERY_CTRL byte 2 value that activates the image
  localparam logic [7:0] ImageActivateCode = 8'h0F;

endpackage
